/* all.f */
+incdir+hw
+incdir+tb
hw/nr_cell_id_pkg.sv
hw/sss_corr_pkg.sv
hw/m_seq_lfsr.sv
hw/sss_detector.sv
hw/sss_search_top.sv
tb/tb_sss_search.sv

/* hw/m_seq_lfsr.sv */
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module m_seq_lfsr #(
    parameter logic [`LFSR_WIDTH - 1:0] TAPS = `X0_TAPS,
    parameter logic [`LFSR_WIDTH - 1:0] SEED = `LFSR_SEED
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic bit_o,
    output logic valid_o
);

    // state[0] holds x(i), state[6] holds x(i+6)
    logic [`LFSR_WIDTH - 1:0] state;
    logic                     feedback;
    logic                     running;

    // next sequence element x(i+7) from the tapped history
    assign feedback = ^(state & TAPS);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state   <= SEED;
            running <= 1'b0;
        end else begin
            // first cycle out of reset only raises valid, so x(0) is not skipped
            running <= 1'b1;
            if (running) begin
                // shift toward bit 0, new element enters at the top
                state <= {feedback, state[`LFSR_WIDTH - 1:1]};
            end
        end
    end

    // oldest element of the window is the current sequence bit
    assign bit_o   = state[0];
    assign valid_o = running;

endmodule

/* hw/nr_cell_id_pkg.sv */
`include "nr_sync_defines.svh"

package nr_cell_id_pkg;

    // physical-layer cell identity fields as seen on the ports

    // group index within the cell id, 0 to 335
    typedef logic [$clog2(`N_ID_1_MAX + 1) - 1:0] n_id_1_t;

    // sector index found by the PSS stage, 0 to 2
    typedef logic [1:0] n_id_2_t;

    // index into one 127-entry sequence, also used for cyclic shifts
    typedef logic [$clog2(`SSS_LEN) - 1:0] seq_idx_t;

endpackage

/* hw/nr_sync_defines.svh */
`ifndef NR_SYNC_DEFINES_SVH
`define NR_SYNC_DEFINES_SVH

// length of one SSS sequence in bits
`define SSS_LEN 127

// N_id_1 candidates run from 0 up to this value
`define N_ID_1_MAX 335

// m1 = N_id_1 mod 112, m0 steps by 15 per group of 112 and by 5 per N_id_2
`define M1_PERIOD 112
`define M0_GROUP_STEP 15
`define M0_N2_STEP 5

// m-sequence generators
`define LFSR_WIDTH 7
// x0: x(i+7) = x(i+4) ^ x(i)
`define X0_TAPS 7'h11
// x1: x(i+7) = x(i+1) ^ x(i)
`define X1_TAPS 7'h03
`define LFSR_SEED 7'h01

`endif

/* hw/sss_corr_pkg.sv */
`include "nr_sync_defines.svh"

package sss_corr_pkg;

    // number of agreeing bits for one candidate, 0 to 127
    typedef logic [$clog2(`SSS_LEN + 1) - 1:0] corr_score_t;

    // detector phase
    typedef enum logic [1:0] {
        CAPTURE,
        COMPARE,
        DECIDE
    } det_state_e;

endpackage

/* hw/sss_detector.sv */
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module sss_detector
    import nr_cell_id_pkg::*;
    import sss_corr_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    input  logic    sss_bit_i,
    input  logic    sss_valid_i,
    input  n_id_2_t n_id_2_i,
    input  logic    n_id_2_valid_i,
    output n_id_1_t n_id_1_o,
    output logic    n_id_1_valid_o
);

    localparam seq_idx_t LAST_IDX = seq_idx_t'(`SSS_LEN - 1);
    localparam seq_idx_t LAST_M1  = seq_idx_t'(`M1_PERIOD - 1);
    localparam n_id_1_t  LAST_ID  = n_id_1_t'(`N_ID_1_MAX);

    // m-sequence generator outputs
    logic x0_bit;
    logic x0_valid;
    logic x1_bit;
    logic x1_valid;

    // received SSS and the two base sequences, index 0 in bit 0
    logic [`SSS_LEN - 1:0] sss_buf;
    logic [`SSS_LEN - 1:0] x0_tab;
    logic [`SSS_LEN - 1:0] x1_tab;

    det_state_e  state;
    seq_idx_t    cap_cnt;
    logic        cap_done;
    seq_idx_t    tab_cnt;
    logic        tab_full;

    // m0 = base + 15 * group, m1 = N_id_1 mod 112
    seq_idx_t    m0_n2;
    seq_idx_t    m0_base;
    seq_idx_t    m0_start;
    seq_idx_t    m0_cur;
    seq_idx_t    m1_cur;
    seq_idx_t    m0_next;
    seq_idx_t    m1_next;
    logic        group_end;

    // compare walk
    seq_idx_t    bit_idx;
    seq_idx_t    rd0;
    seq_idx_t    rd1;
    logic        ref_bit;
    logic        agree;
    corr_score_t score;

    // best candidate so far
    corr_score_t best_score;
    n_id_1_t     cand;
    n_id_1_t     best_id;
    n_id_1_t     winner;
    logic        better;

    logic        cap_take;
    logic        cap_last;
    logic        tab_take;
    logic        tab_last;
    logic        bits_ready;
    logic        tabs_ready;

    // cyclic increment modulo 127
    function automatic seq_idx_t wrap_inc(input seq_idx_t idx);
        seq_idx_t nxt;
        nxt = seq_idx_t'(idx + 1'b1);
        if (idx == LAST_IDX) begin
            nxt = '0;
        end
        return nxt;
    endfunction

    m_seq_lfsr #(
        .TAPS (`X0_TAPS),
        .SEED (`LFSR_SEED)
    ) u_lfsr_x0 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .bit_o    (x0_bit),
        .valid_o  (x0_valid)
    );

    m_seq_lfsr #(
        .TAPS (`X1_TAPS),
        .SEED (`LFSR_SEED)
    ) u_lfsr_x1 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .bit_o    (x1_bit),
        .valid_o  (x1_valid)
    );

    // 5 * N_id_2 by lookup
    always_comb begin
        case (n_id_2_i)
            2'd1:    m0_n2 = seq_idx_t'(`M0_N2_STEP);
            2'd2:    m0_n2 = seq_idx_t'(`M0_N2_STEP + `M0_N2_STEP);
            default: m0_n2 = '0;
        endcase
    end

    // a strobe in the same cycle as the last bit still counts
    assign m0_start = n_id_2_valid_i ? m0_n2 : m0_base;

    // capture and table fill conditions
    assign cap_take   = (state == CAPTURE) && sss_valid_i && !cap_done;
    assign cap_last   = cap_take && (cap_cnt == LAST_IDX);
    assign tab_take   = x0_valid && x1_valid && !tab_full;
    assign tab_last   = tab_take && (tab_cnt == LAST_IDX);
    assign bits_ready = cap_done || cap_last;
    assign tabs_ready = tab_full || tab_last;

    // candidate bit n is x0[(n + m0) mod 127] ^ x1[(n + m1) mod 127]
    assign ref_bit = x0_tab[rd0] ^ x1_tab[rd1];
    assign agree   = (sss_buf[bit_idx] == ref_bit);

    // ties keep the lower N_id_1
    assign better = (score > best_score);
    assign winner = better ? cand : best_id;

    // shift update for the next candidate
    assign group_end = (m1_cur == LAST_M1);
    assign m1_next   = group_end ? '0 : seq_idx_t'(m1_cur + 1'b1);
    assign m0_next   = group_end ? seq_idx_t'(m0_cur + `M0_GROUP_STEP) : m0_cur;

    // sequence storage
    always_ff @(posedge clk_i) begin
        if (cap_take) begin
            sss_buf[cap_cnt] <= sss_bit_i;
        end
        if (tab_take) begin
            x0_tab[tab_cnt] <= x0_bit;
            x1_tab[tab_cnt] <= x1_bit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state          <= CAPTURE;
            cap_cnt        <= '0;
            cap_done       <= 1'b0;
            tab_cnt        <= '0;
            tab_full       <= 1'b0;
            m0_base        <= '0;
            m0_cur         <= '0;
            m1_cur         <= '0;
            bit_idx        <= '0;
            rd0            <= '0;
            rd1            <= '0;
            score          <= '0;
            best_score     <= '0;
            cand           <= '0;
            best_id        <= '0;
            n_id_1_o       <= '0;
            n_id_1_valid_o <= 1'b0;
        end else begin
            n_id_1_valid_o <= 1'b0;

            // tables fill once after reset and are then kept
            if (tab_take) begin
                tab_cnt <= seq_idx_t'(tab_cnt + 1'b1);
                if (tab_last) begin
                    tab_full <= 1'b1;
                end
            end

            case (state)
                CAPTURE: begin
                    if (n_id_2_valid_i) begin
                        m0_base <= m0_n2;
                    end
                    if (cap_take) begin
                        cap_cnt <= seq_idx_t'(cap_cnt + 1'b1);
                        if (cap_last) begin
                            cap_done <= 1'b1;
                        end
                    end
                    // start with candidate 0, m1 = 0
                    if (bits_ready && tabs_ready) begin
                        state      <= COMPARE;
                        m0_cur     <= m0_start;
                        m1_cur     <= '0;
                        rd0        <= m0_start;
                        rd1        <= '0;
                        bit_idx    <= '0;
                        score      <= '0;
                        best_score <= '0;
                        cand       <= '0;
                        best_id    <= '0;
                    end
                end

                COMPARE: begin
                    // one bit per cycle, both read pointers wrap at 127
                    if (agree) begin
                        score <= corr_score_t'(score + 1'b1);
                    end
                    rd0 <= wrap_inc(rd0);
                    rd1 <= wrap_inc(rd1);
                    if (bit_idx == LAST_IDX) begin
                        bit_idx <= '0;
                        state   <= DECIDE;
                    end else begin
                        bit_idx <= seq_idx_t'(bit_idx + 1'b1);
                    end
                end

                DECIDE: begin
                    if (better) begin
                        best_score <= score;
                        best_id    <= cand;
                    end
                    if (cand == LAST_ID) begin
                        // all 336 scored, report and rearm capture
                        n_id_1_o       <= winner;
                        n_id_1_valid_o <= 1'b1;
                        state          <= CAPTURE;
                        cap_cnt        <= '0;
                        cap_done       <= 1'b0;
                        score          <= '0;
                        best_score     <= '0;
                        cand           <= '0;
                        m1_cur         <= '0;
                        m0_cur         <= m0_base;
                    end else begin
                        cand   <= n_id_1_t'(cand + 1'b1);
                        m0_cur <= m0_next;
                        m1_cur <= m1_next;
                        rd0    <= m0_next;
                        rd1    <= m1_next;
                        score  <= '0;
                        state  <= COMPARE;
                    end
                end

                default: begin
                    state <= CAPTURE;
                end
            endcase
        end
    end

endmodule

/* hw/sss_search_top.sv */
`timescale 1ns/1ps

module sss_search_top
    import nr_cell_id_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    // hard-decided SSS bits, index 0 first
    input  logic    sss_bit_i,
    input  logic    sss_valid_i,
    // sector id from the PSS stage
    input  n_id_2_t n_id_2_i,
    input  logic    n_id_2_valid_i,
    // detected group id, valid is a one-cycle pulse
    output n_id_1_t n_id_1_o,
    output logic    n_id_1_valid_o
);

    n_id_1_t det_n_id_1;
    logic    det_n_id_1_valid;

    // no extra pipeline stage at this level
    sss_detector u_sss_detector (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sss_bit_i      (sss_bit_i),
        .sss_valid_i    (sss_valid_i),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_1_o       (det_n_id_1),
        .n_id_1_valid_o (det_n_id_1_valid)
    );

    assign n_id_1_o       = det_n_id_1;
    assign n_id_1_valid_o = det_n_id_1_valid;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SSS search testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_sss_search \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"

/* tb/sss_ref_model.svh */
`ifndef SSS_REF_MODEL_SVH
`define SSS_REF_MODEL_SVH

// reference x0 and x1, element i sits in bit i
logic [`SSS_LEN - 1:0] ref_x0;
logic [`SSS_LEN - 1:0] ref_x1;

// NR recurrences, both start from x(0) = 1 and x(1) .. x(6) = 0
function automatic void build_m_sequences();
    int i;
    ref_x0    = '0;
    ref_x1    = '0;
    ref_x0[0] = 1'b1;
    ref_x1[0] = 1'b1;
    for (i = 0; i < `SSS_LEN - 7; i++) begin
        // x0(i+7) = x0(i+4) + x0(i) mod 2
        ref_x0[seq_idx_t'(i + 7)] = ref_x0[seq_idx_t'(i + 4)] ^ ref_x0[seq_idx_t'(i)];
        // x1(i+7) = x1(i+1) + x1(i) mod 2
        ref_x1[seq_idx_t'(i + 7)] = ref_x1[seq_idx_t'(i + 1)] ^ ref_x1[seq_idx_t'(i)];
    end
endfunction

// hard-bit SSS of one candidate, bit n is x0 at n + m0 xor x1 at n + m1
function automatic logic [`SSS_LEN - 1:0] candidate_sss(input int n1, input int n2);
    logic [`SSS_LEN - 1:0] seq;
    int                    m0;
    int                    m1;
    int                    n;
    m0 = `M0_GROUP_STEP * (n1 / `M1_PERIOD) + `M0_N2_STEP * n2;
    m1 = n1 % `M1_PERIOD;
    for (n = 0; n < `SSS_LEN; n++) begin
        seq[seq_idx_t'(n)] = ref_x0[seq_idx_t'((n + m0) % `SSS_LEN)]
                           ^ ref_x1[seq_idx_t'((n + m1) % `SSS_LEN)];
    end
    return seq;
endfunction

// number of positions where received and candidate bits agree
function automatic int agreement_count(input logic [`SSS_LEN - 1:0] rx,
                                       input logic [`SSS_LEN - 1:0] cand);
    return $countones(~(rx ^ cand));
endfunction

// argmax over all candidates for the given N_id_2
function automatic int best_candidate(input logic [`SSS_LEN - 1:0] rx, input int n2);
    int n1;
    int score;
    int best_score;
    int best_n1;
    best_score = -1;
    best_n1    = 0;
    for (n1 = 0; n1 <= `N_ID_1_MAX; n1++) begin
        score = agreement_count(rx, candidate_sss(n1, n2));
        // strictly greater, so on a tie the lower N_id_1 stays
        if (score > best_score) begin
            best_score = score;
            best_n1    = n1;
        end
    end
    return best_n1;
endfunction

`endif

/* tb/tb_sss_search.sv */
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module tb_sss_search
    import nr_cell_id_pkg::*;
();

    // edges from the edge that accepts bit 126 up to the result pulse
    localparam int SEARCH_EDGES   = (`N_ID_1_MAX + 1) * (`SSS_LEN + 1);
    localparam int FRAME_CYCLES   = 43400;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 2000;
    // both LFSR tables are full about 128 cycles after reset
    localparam int TABLE_WAIT     = 140;
    // junk stops well before the detector rearms capture
    localparam int JUNK_CYCLES    = SEARCH_EDGES - 8;

    logic    clk_i;
    logic    reset_ni;
    logic    sss_bit_i;
    logic    sss_valid_i;
    n_id_2_t n_id_2_i;
    logic    n_id_2_valid_i;
    n_id_1_t n_id_1_o;
    logic    n_id_1_valid_o;

    int      error_cnt;
    int      frame_cnt;
    int      cycle_cnt;
    // high only while a result is awaited
    logic    result_allowed;

    `include "sss_ref_model.svh"

    sss_search_top u_dut (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sss_bit_i      (sss_bit_i),
        .sss_valid_i    (sss_valid_i),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_1_o       (n_id_1_o),
        .n_id_1_valid_o (n_id_1_valid_o)
    );

    // 40 ns clock
    always #20 clk_i = ~clk_i;

    // hang guard
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("simulation hang, the run did not finish within %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // no pulse may appear while no result is awaited
    always @(negedge clk_i) begin
        if (n_id_1_valid_o && !result_allowed) begin
            error_cnt++;
            $display("unexpected result pulse at %0t while no search was running", $time);
        end
    end

    task automatic report_mismatch(input string what, input int expected, input int observed);
        error_cnt++;
        $display("CHECK FAILED at %0t: %s expected %0d observed %0d",
                 $time, what, expected, observed);
    endtask

    // 127 bits on consecutive cycles with the N_id_2 strobe on bit 0
    task automatic send_frame(input logic [`SSS_LEN - 1:0] bits, input n_id_2_t n2);
        int i;
        for (i = 0; i < `SSS_LEN; i++) begin
            @(posedge clk_i);
            sss_valid_i    <= 1'b1;
            sss_bit_i      <= bits[seq_idx_t'(i)];
            n_id_2_valid_i <= (i == 0);
            n_id_2_i       <= n2;
        end
        // this edge accepts bit 126
        @(posedge clk_i);
        sss_valid_i    <= 1'b0;
        sss_bit_i      <= 1'b0;
        n_id_2_valid_i <= 1'b0;
    endtask

    // count edges up to the pulse with outputs sampled at the falling edge
    task automatic wait_result(input int expected);
        int edges;
        edges          = 0;
        result_allowed = 1'b1;
        do begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end while (!n_id_1_valid_o);
        if (edges != SEARCH_EDGES) begin
            report_mismatch("result latency in edges", SEARCH_EDGES, edges);
        end
        if (int'(n_id_1_o) != expected) begin
            report_mismatch("n_id_1_o", expected, int'(n_id_1_o));
        end
        @(negedge clk_i);
        if (n_id_1_valid_o) begin
            report_mismatch("n_id_1_valid_o one cycle after the pulse", 0, 1);
        end
        result_allowed = 1'b0;
    endtask

    // random bits and a wrong N_id_2 strobe while the search runs
    task automatic drive_junk(input int n_cycles, input n_id_2_t n2_other);
        int k;
        for (k = 0; k < n_cycles; k++) begin
            @(posedge clk_i);
            sss_valid_i    <= 1'b1;
            sss_bit_i      <= 1'($urandom);
            n_id_2_i       <= n2_other;
            n_id_2_valid_i <= ($urandom_range(0, 63) == 0);
        end
        @(posedge clk_i);
        sss_valid_i    <= 1'b0;
        sss_bit_i      <= 1'b0;
        n_id_2_valid_i <= 1'b0;
    endtask

    task automatic run_frame(input logic [`SSS_LEN - 1:0] bits, input n_id_2_t n2,
                             input int expected);
        send_frame(bits, n2);
        wait_result(expected);
        frame_cnt++;
        repeat (4) @(posedge clk_i);
    endtask

    // between 1 and 30 distinct positions to invert
    function automatic logic [`SSS_LEN - 1:0] flip_mask();
        logic [`SSS_LEN - 1:0] mask;
        int                    n_flips;
        int                    idx;
        mask    = '0;
        n_flips = $urandom_range(1, 30);
        while ($countones(mask) < n_flips) begin
            idx = $urandom_range(0, `SSS_LEN - 1);
            mask[seq_idx_t'(idx)] = 1'b1;
        end
        return mask;
    endfunction

    // received bits that agree with two candidates of one group equally often
    function automatic logic [`SSS_LEN - 1:0] tie_between(input int n1_lo, input int n1_hi,
                                                         input int n2);
        logic [`SSS_LEN - 1:0] seq_lo;
        logic [`SSS_LEN - 1:0] seq_hi;
        logic [`SSS_LEN - 1:0] rx;
        int                    n_diff;
        int                    n;
        seq_lo = candidate_sss(n1_lo, n2);
        seq_hi = candidate_sss(n1_hi, n2);
        rx     = seq_lo;
        n_diff = 0;
        // every second place where the two differ follows the higher candidate
        for (n = 0; n < `SSS_LEN; n++) begin
            if (seq_lo[seq_idx_t'(n)] != seq_hi[seq_idx_t'(n)]) begin
                if (n_diff % 2 == 1) begin
                    rx[seq_idx_t'(n)] = seq_hi[seq_idx_t'(n)];
                end
                n_diff++;
            end
        end
        return rx;
    endfunction

    initial begin
        int                    g;
        int                    k;
        int                    n1;
        int                    n1_lo;
        int                    n1_hi;
        int                    n2;
        int                    n2_other;
        logic [`SSS_LEN - 1:0] bits;

        clk_i          = 1'b0;
        reset_ni       = 1'b0;
        sss_bit_i      = 1'b0;
        sss_valid_i    = 1'b0;
        n_id_2_i       = '0;
        n_id_2_valid_i = 1'b0;
        error_cnt      = 0;
        frame_cnt      = 0;
        cycle_cnt      = 0;
        result_allowed = 1'b0;
        void'($urandom(32'ha988));
        build_m_sequences();

        repeat (16) @(posedge clk_i);
        reset_ni <= 1'b1;
        repeat (TABLE_WAIT) @(posedge clk_i);

        // exact SSS with one candidate per 112 group and N_id_2 0 to 2
        for (g = 0; g < 3; g++) begin
            n1 = g * `M1_PERIOD + $urandom_range(0, `M1_PERIOD - 1);
            run_frame(candidate_sss(n1, g), n_id_2_t'(g), n1);
        end

        // a few flipped bits against the model's argmax
        for (g = 0; g < 2; g++) begin
            n1   = $urandom_range(0, `N_ID_1_MAX);
            n2   = $urandom_range(0, 2);
            bits = candidate_sss(n1, n2) ^ flip_mask();
            run_frame(bits, n_id_2_t'(n2), best_candidate(bits, n2));
        end

        // exact tie inside one group where the lower N_id_1 has to win
        g     = $urandom_range(0, 2);
        n2    = $urandom_range(0, 2);
        n1_lo = g * `M1_PERIOD + $urandom_range(0, `M1_PERIOD / 2 - 1);
        n1_hi = g * `M1_PERIOD + $urandom_range(`M1_PERIOD / 2, `M1_PERIOD - 1);
        bits  = tie_between(n1_lo, n1_hi, n2);
        run_frame(bits, n_id_2_t'(n2), best_candidate(bits, n2));

        // pure noise against the model's argmax
        for (g = 0; g < 2; g++) begin
            n2 = $urandom_range(0, 2);
            for (k = 0; k < `SSS_LEN; k++) begin
                bits[seq_idx_t'(k)] = 1'($urandom);
            end
            run_frame(bits, n_id_2_t'(n2), best_candidate(bits, n2));
        end

        // junk during the search must not disturb the result
        n1       = $urandom_range(0, `N_ID_1_MAX);
        n2       = $urandom_range(0, 2);
        n2_other = (n2 + 1 + $urandom_range(0, 1)) % 3;
        send_frame(candidate_sss(n1, n2), n_id_2_t'(n2));
        fork
            wait_result(n1);
            drive_junk(JUNK_CYCLES, n_id_2_t'(n2_other));
        join
        frame_cnt++;
        repeat (4) @(posedge clk_i);
        // next frame with the other N_id_2
        n1 = $urandom_range(0, `N_ID_1_MAX);
        run_frame(candidate_sss(n1, n2_other), n_id_2_t'(n2_other), n1);

        // reset partway through a search and no pulse may follow
        n1 = $urandom_range(0, `N_ID_1_MAX);
        n2 = $urandom_range(0, 2);
        send_frame(candidate_sss(n1, n2), n_id_2_t'(n2));
        repeat (1000) @(posedge clk_i);
        reset_ni <= 1'b0;
        repeat (16) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        if (n_id_1_o != '0) begin
            report_mismatch("n_id_1_o after reset", 0, int'(n_id_1_o));
        end
        // past the edge where the aborted result would have come
        repeat (SEARCH_EDGES - 900) @(posedge clk_i);
        n1 = $urandom_range(0, `N_ID_1_MAX);
        n2 = $urandom_range(0, 2);
        run_frame(candidate_sss(n1, n2), n_id_2_t'(n2), n1);

        $display("errors: %0d, frames checked: %0d", error_cnt, frame_cnt);
        if (error_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
